// File: hdl/mist_video_pkg.sv
/* MiST video pipeline types and constants */

package mist_video_pkg;

	// One color channel at the pins
	localparam int COLOR_W = 6;
	typedef logic [COLOR_W-1:0] color_t;

	// Scandoubler horizontal counter
	localparam int SD_HCNT_WIDTH = 10;
	typedef logic [SD_HCNT_WIDTH-1:0] hcnt_t;

	// Line buffer address width per half, one entry every fourth cycle
	localparam int SD_BUF_AW = SD_HCNT_WIDTH - 2;

	// Scanline darkening levels
	typedef logic [1:0] scanlines_t;
	localparam scanlines_t SL_NONE = 2'd0;
	localparam scanlines_t SL_25   = 2'd1;
	localparam scanlines_t SL_50   = 2'd2;
	localparam scanlines_t SL_75   = 2'd3;

	// OSD bitmap byte address, 256 bytes of 8 vertical dots each
	typedef logic [7:0] osd_addr_t;

	typedef enum logic {
		SPI_CMD,
		SPI_DATA
	} spi_state_t;

	// OSD window size in dots
	localparam int OSD_COLS = 64;
	localparam int OSD_ROWS = 32;

	// Window start, cycles after hsync falls and lines after vsync falls
	localparam hcnt_t OSD_X_OFFSET = 10'd32;
	localparam hcnt_t OSD_Y_OFFSET = 10'd4;

	// Lit dot color as {red, green, blue}
	localparam logic [2:0] OSD_COLOR = 3'b100;

	// SPI command bytes
	localparam logic [7:0] OSD_CMD_WRITE   = 8'h20;
	localparam logic [7:0] OSD_CMD_ENABLE  = 8'h41;
	localparam logic [7:0] OSD_CMD_DISABLE = 8'h40;

endpackage

// File: hdl/video_if.sv
/* Video stream bundle */

`timescale 1ns/1ps

interface video_if;

	mist_video_pkg::color_t r;
	mist_video_pkg::color_t g;
	mist_video_pkg::color_t b;
	// Active high sync pulses
	logic                   hs;
	logic                   vs;

	modport src (
		output r, g, b,
		output hs, vs
	);

	modport snk (
		input r, g, b,
		input hs, vs
	);

endinterface

// File: hdl/scandoubler.sv
/* 15 to 31 kHz scandoubler */

`timescale 1ns/1ps

module scandoubler (
	input  logic                       clk_sys,
	input  logic                       rst_i,
	input  mist_video_pkg::scanlines_t scanlines_i,
	input  mist_video_pkg::color_t     r_i,
	input  mist_video_pkg::color_t     g_i,
	input  mist_video_pkg::color_t     b_i,
	input  logic                       hs_i,
	input  logic                       vs_i,
	video_if.src                       out
);

	// Input line measurement
	logic                  hs_d;
	logic                  hs_rise;
	logic                  hs_fall;
	mist_video_pkg::hcnt_t hcnt;
	mist_video_pkg::hcnt_t hs_max;
	mist_video_pkg::hcnt_t hs_len;
	logic                  line_toggle;

	// Playout counter running twice per input line
	mist_video_pkg::hcnt_t sd_hcnt;
	logic                  sd_second;
	logic                  sd_hs;

	// Two halves, one written while the other plays out
	logic [3*mist_video_pkg::COLOR_W-1:0] line_buf [2**(mist_video_pkg::SD_BUF_AW+1)];
	logic [mist_video_pkg::SD_BUF_AW:0]   wr_addr;
	logic [mist_video_pkg::SD_BUF_AW:0]   rd_addr;
	logic [3*mist_video_pkg::COLOR_W-1:0] rd_q;

	logic                       sec_q;
	logic                       hs_q;
	logic                       vs_q;
	mist_video_pkg::scanlines_t sl_sel;

	function automatic mist_video_pkg::color_t darken(
		mist_video_pkg::color_t     c,
		mist_video_pkg::scanlines_t sl
	);
		case (sl)
			mist_video_pkg::SL_25: darken = c - (c >> 2);
			mist_video_pkg::SL_50: darken = c >> 1;
			mist_video_pkg::SL_75: darken = c >> 2;
			default:               darken = c;
		endcase
	endfunction

	assign hs_rise = hs_i & ~hs_d;
	assign hs_fall = ~hs_i & hs_d;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			hs_d        <= 1'b0;
			hcnt        <= '0;
			hs_max      <= '0;
			hs_len      <= '0;
			line_toggle <= 1'b0;
		end else begin
			hs_d <= hs_i;
			if (hs_rise) begin
				hcnt        <= '0;
				hs_max      <= hcnt;
				line_toggle <= ~line_toggle;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
			// Pulse width counted from the rising edge
			if (hs_fall)
				hs_len <= hcnt + 1'b1;
		end
	end

	// Sample near the middle of each 4 cycle input pixel
	assign wr_addr = {line_toggle, hcnt[mist_video_pkg::SD_HCNT_WIDTH-1:2]};

	always_ff @(posedge clk_sys) begin
		if (hcnt[1:0] == 2'd1)
			line_buf[wr_addr] <= {r_i, g_i, b_i};
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			sd_hcnt   <= '0;
			sd_second <= 1'b0;
		end else if (hs_rise) begin
			sd_hcnt   <= '0;
			sd_second <= 1'b0;
		end else if (sd_hcnt == (hs_max >> 1)) begin
			// Half line done, replay the same line
			sd_hcnt   <= '0;
			sd_second <= 1'b1;
		end else begin
			sd_hcnt <= sd_hcnt + 1'b1;
		end
	end

	// Read the finished half at one pixel per 2 cycles
	assign rd_addr = {~line_toggle, sd_hcnt[mist_video_pkg::SD_BUF_AW:1]};
	assign sd_hs   = sd_hcnt < (hs_len >> 1);

	always_ff @(posedge clk_sys) begin
		rd_q <= line_buf[rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			sec_q <= 1'b0;
			hs_q  <= 1'b0;
			vs_q  <= 1'b0;
		end else begin
			sec_q <= sd_second;
			hs_q  <= sd_hs;
			if (sd_hcnt == '0)
				vs_q <= vs_i;
		end
	end

	// Only the repeated line gets darkened
	assign sl_sel = sec_q ? scanlines_i : mist_video_pkg::SL_NONE;

	always_ff @(posedge clk_sys) begin
		out.r <= darken(rd_q[3*mist_video_pkg::COLOR_W-1:2*mist_video_pkg::COLOR_W], sl_sel);
		out.g <= darken(rd_q[2*mist_video_pkg::COLOR_W-1:mist_video_pkg::COLOR_W], sl_sel);
		out.b <= darken(rd_q[mist_video_pkg::COLOR_W-1:0], sl_sel);
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			out.hs <= 1'b0;
			out.vs <= 1'b0;
		end else begin
			out.hs <= hs_q;
			out.vs <= vs_q;
		end
	end

endmodule

// File: hdl/osd.sv
/* OSD overlay with SPI loader */

`timescale 1ns/1ps

module osd (
	input  logic clk_sys,
	input  logic rst_i,
	input  logic spi_sck_i,
	input  logic spi_ss_i,
	input  logic spi_di_i,
	video_if.snk in,
	video_if.src out
);

	// SPI lines brought into clk_sys, extra sck stage for edge detect
	logic [2:0] sck_q;
	logic [1:0] ss_q;
	logic [1:0] di_q;
	logic       sck_rise;
	logic       selected;

	mist_video_pkg::spi_state_t state;
	logic [2:0]                 bit_cnt;
	logic [6:0]                 shift_q;
	logic [7:0]                 spi_byte;
	logic                       byte_done;
	mist_video_pkg::osd_addr_t  wr_addr;
	logic                       osd_en;

	logic [7:0] bitmap [2**$bits(mist_video_pkg::osd_addr_t)];

	// Position inside the frame
	logic                      hs_d;
	logic                      vs_d;
	logic                      hs_fall;
	logic                      vs_fall;
	mist_video_pkg::hcnt_t     h_cnt;
	mist_video_pkg::hcnt_t     v_cnt;
	mist_video_pkg::hcnt_t     h_rel;
	mist_video_pkg::hcnt_t     v_rel;
	logic                      in_win;
	logic [5:0]                dot_col;
	logic [4:0]                dot_row;
	mist_video_pkg::osd_addr_t rd_addr;
	logic                      lit;
	logic                      active;

	function automatic mist_video_pkg::color_t overlay(
		mist_video_pkg::color_t c,
		logic                   act,
		logic                   dot,
		logic                   sel
	);
		if (!act)
			overlay = c;
		else if (dot && sel)
			overlay = '1;
		else
			overlay = c >> 1;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			sck_q <= '0;
			ss_q  <= '1;
			di_q  <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_sck_i};
			ss_q  <= {ss_q[0], spi_ss_i};
			di_q  <= {di_q[0], spi_di_i};
		end
	end

	assign sck_rise  = sck_q[1] & ~sck_q[2];
	assign selected  = ~ss_q[1];
	// MSB first
	assign spi_byte  = {shift_q, di_q[1]};
	assign byte_done = selected && sck_rise && (bit_cnt == 3'd7);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			state   <= mist_video_pkg::SPI_CMD;
			bit_cnt <= '0;
			shift_q <= '0;
			wr_addr <= '0;
			osd_en  <= 1'b0;
		end else if (!selected) begin
			state   <= mist_video_pkg::SPI_CMD;
			bit_cnt <= '0;
			wr_addr <= '0;
		end else if (sck_rise) begin
			shift_q <= spi_byte[6:0];
			bit_cnt <= bit_cnt + 3'd1;
			if (byte_done) begin
				case (state)
					mist_video_pkg::SPI_CMD: begin
						if (spi_byte == mist_video_pkg::OSD_CMD_WRITE)
							state <= mist_video_pkg::SPI_DATA;
						else if (spi_byte == mist_video_pkg::OSD_CMD_ENABLE)
							osd_en <= 1'b1;
						else if (spi_byte == mist_video_pkg::OSD_CMD_DISABLE)
							osd_en <= 1'b0;
					end
					default: wr_addr <= wr_addr + 1'b1;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_done && state == mist_video_pkg::SPI_DATA)
			bitmap[wr_addr] <= spi_byte;
	end

	assign hs_fall = hs_d & ~in.hs;
	assign vs_fall = vs_d & ~in.vs;

	// h_cnt is 0 on the cycle after hsync is first seen low
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			hs_d  <= 1'b0;
			vs_d  <= 1'b0;
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			hs_d <= in.hs;
			vs_d <= in.vs;
			if (hs_fall)
				h_cnt <= '0;
			else if (h_cnt != '1)
				h_cnt <= h_cnt + 1'b1;
			if (vs_fall)
				v_cnt <= '0;
			else if (hs_fall && v_cnt != '1)
				v_cnt <= v_cnt + 1'b1;
		end
	end

	assign h_rel  = h_cnt - mist_video_pkg::OSD_X_OFFSET;
	assign v_rel  = v_cnt - mist_video_pkg::OSD_Y_OFFSET;
	assign in_win = (h_cnt >= mist_video_pkg::OSD_X_OFFSET) &&
		(h_rel < mist_video_pkg::hcnt_t'(2 * mist_video_pkg::OSD_COLS)) &&
		(v_cnt >= mist_video_pkg::OSD_Y_OFFSET) &&
		(v_rel < mist_video_pkg::hcnt_t'(mist_video_pkg::OSD_ROWS));

	// Each dot is 2 cycles wide, a byte holds 8 rows of one column
	assign dot_col = h_rel[6:1];
	assign dot_row = v_rel[4:0];
	assign rd_addr = {dot_col, dot_row[4:3]};
	assign lit     = bitmap[rd_addr][dot_row[2:0]];
	assign active  = osd_en && in_win;

	always_ff @(posedge clk_sys) begin
		out.r <= overlay(in.r, active, lit, mist_video_pkg::OSD_COLOR[2]);
		out.g <= overlay(in.g, active, lit, mist_video_pkg::OSD_COLOR[1]);
		out.b <= overlay(in.b, active, lit, mist_video_pkg::OSD_COLOR[0]);
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			out.hs <= 1'b0;
			out.vs <= 1'b0;
		end else begin
			out.hs <= in.hs;
			out.vs <= in.vs;
		end
	end

endmodule

// File: hdl/video_out_encoder.sv
/* YPbPr and sync output stage */

`timescale 1ns/1ps

module video_out_encoder (
	input  logic                   clk_sys,
	input  logic                   rst_i,
	input  logic                   ypbpr_i,
	input  logic                   scandoubler_disable_i,
	video_if.snk                   in,
	output mist_video_pkg::color_t vga_r_o,
	output mist_video_pkg::color_t vga_g_o,
	output mist_video_pkg::color_t vga_b_o,
	output logic                   vga_hs_o,
	output logic                   vga_vs_o
);

	logic [11:0]        y_sum;
	logic signed [12:0] rs;
	logic signed [12:0] gs;
	logic signed [12:0] bs;
	logic signed [12:0] pb_sum;
	logic signed [12:0] pr_sum;
	logic               use_cs;
	logic               cs;

	function automatic mist_video_pkg::color_t clamp6(logic signed [12:0] v);
		if (v < 0)
			clamp6 = '0;
		else if (v > 63)
			clamp6 = '1;
		else
			clamp6 = mist_video_pkg::color_t'(v[5:0]);
	endfunction

	assign rs = {7'd0, in.r};
	assign gs = {7'd0, in.g};
	assign bs = {7'd0, in.b};

	assign y_sum  = 19 * in.r + 37 * in.g + 8 * in.b;
	assign pb_sum = 32 * bs - 11 * rs - 21 * gs;
	assign pr_sum = 32 * rs - 27 * gs - 5 * bs;

	// Scart and YPbPr both want composite sync on the hsync pin
	assign use_cs = scandoubler_disable_i | ypbpr_i;
	assign cs     = ~(in.hs ^ in.vs);

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			vga_r_o  <= '0;
			vga_g_o  <= '0;
			vga_b_o  <= '0;
			vga_hs_o <= 1'b0;
			vga_vs_o <= 1'b0;
		end else begin
			vga_r_o  <= ypbpr_i ? clamp6(13'sd32 + (pr_sum >>> 6)) : in.r;
			vga_g_o  <= ypbpr_i ? y_sum[11:6] : in.g;
			vga_b_o  <= ypbpr_i ? clamp6(13'sd32 + (pb_sum >>> 6)) : in.b;
			vga_hs_o <= use_cs ? cs : in.hs;
			vga_vs_o <= use_cs ? 1'b1 : in.vs;
		end
	end

endmodule

// File: hdl/mist_video.sv
/* MiST video output pipeline */

`timescale 1ns/1ps

module mist_video #(
	parameter int COLOR_DEPTH = 6
) (
	input  logic                       clk_sys,
	input  logic                       rst_i,
	input  logic [COLOR_DEPTH-1:0]     r_i,
	input  logic [COLOR_DEPTH-1:0]     g_i,
	input  logic [COLOR_DEPTH-1:0]     b_i,
	input  logic                       hs_i,
	input  logic                       vs_i,
	input  logic                       spi_sck_i,
	input  logic                       spi_ss_i,
	input  logic                       spi_di_i,
	input  mist_video_pkg::scanlines_t scanlines_i,
	input  logic                       scandoubler_disable_i,
	input  logic                       ypbpr_i,
	output mist_video_pkg::color_t     vga_r_o,
	output mist_video_pkg::color_t     vga_g_o,
	output mist_video_pkg::color_t     vga_b_o,
	output logic                       vga_hs_o,
	output logic                       vga_vs_o
);

	logic [COLOR_DEPTH-1:0] raw  [3];
	mist_video_pkg::color_t wide [3];

	video_if sd_bus ();
	video_if mix_bus ();
	video_if osd_bus ();

	assign raw[0] = r_i;
	assign raw[1] = g_i;
	assign raw[2] = b_i;

	// Fill 6 bits by repeating the input or appending its upper bits
	for (genvar ch = 0; ch < 3; ch++) begin : g_widen
		if (COLOR_DEPTH == mist_video_pkg::COLOR_W) begin : g_full
			assign wide[ch] = raw[ch];
		end else if (COLOR_DEPTH == 1 || COLOR_DEPTH == 2) begin : g_rep
			assign wide[ch] = {(mist_video_pkg::COLOR_W / COLOR_DEPTH){raw[ch]}};
		end else begin : g_msb
			assign wide[ch] = {raw[ch],
				raw[ch][COLOR_DEPTH-1 -: mist_video_pkg::COLOR_W - COLOR_DEPTH]};
		end
	end

	scandoubler i_scandoubler (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.scanlines_i (scanlines_i),
		.r_i         (wide[0]),
		.g_i         (wide[1]),
		.b_i         (wide[2]),
		.hs_i        (hs_i),
		.vs_i        (vs_i),
		.out         (sd_bus)
	);

	// Native 15 kHz stream or the doubled one
	always_comb begin
		if (scandoubler_disable_i) begin
			mix_bus.r  = wide[0];
			mix_bus.g  = wide[1];
			mix_bus.b  = wide[2];
			mix_bus.hs = hs_i;
			mix_bus.vs = vs_i;
		end else begin
			mix_bus.r  = sd_bus.r;
			mix_bus.g  = sd_bus.g;
			mix_bus.b  = sd_bus.b;
			mix_bus.hs = sd_bus.hs;
			mix_bus.vs = sd_bus.vs;
		end
	end

	osd i_osd (
		.clk_sys   (clk_sys),
		.rst_i     (rst_i),
		.spi_sck_i (spi_sck_i),
		.spi_ss_i  (spi_ss_i),
		.spi_di_i  (spi_di_i),
		.in        (mix_bus),
		.out       (osd_bus)
	);

	video_out_encoder i_encoder (
		.clk_sys               (clk_sys),
		.rst_i                 (rst_i),
		.ypbpr_i               (ypbpr_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.in                    (osd_bus),
		.vga_r_o               (vga_r_o),
		.vga_g_o               (vga_g_o),
		.vga_b_o               (vga_b_o),
		.vga_hs_o              (vga_hs_o),
		.vga_vs_o              (vga_vs_o)
	);

endmodule

// File: bench/mist_video_assertions.sv
/* Output sync and reset assertions */

`timescale 1ns/1ps

module mist_video_assertions (
	input logic                   clk_i,
	input logic                   rst_i,
	input logic                   scandoubler_disable_i,
	input logic                   ypbpr_i,
	input mist_video_pkg::color_t vga_r_i,
	input mist_video_pkg::color_t vga_g_i,
	input mist_video_pkg::color_t vga_b_i,
	input logic                   vga_hs_i,
	input logic                   vga_vs_i
);

	logic use_cs;

	assign use_cs = scandoubler_disable_i | ypbpr_i;

	// Registered pins come out of reset dark with both syncs low
	property p_reset_clears;
		@(posedge clk_i) rst_i |=> (vga_r_i == '0 && vga_g_i == '0 && vga_b_i == '0 &&
			!vga_hs_i && !vga_vs_i);
	endproperty

	a_reset_clears: assert property (p_reset_clears)
		else $error("VGA outputs not cleared one cycle after reset");

	// Composite sync parks the vsync pin high
	property p_csync_vs_high;
		@(posedge clk_i) disable iff (rst_i) use_cs |=> vga_vs_i;
	endproperty

	a_csync_vs_high: assert property (p_csync_vs_high)
		else $error("vga_vs_o not held at 1 while composite sync was selected");

endmodule

// File: bench/video_checker.sv
/* Video pipeline checker */

`timescale 1ns/1ps

module video_checker #(
	parameter int COLOR_DEPTH = 4
) (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic [3:0]                 test_id_i,
	input  logic                       check_en_i,
	input  logic                       done_i,
	input  logic [7:0]                 bitmap_i [256],
	input  logic [COLOR_DEPTH-1:0]     r_i,
	input  logic [COLOR_DEPTH-1:0]     g_i,
	input  logic [COLOR_DEPTH-1:0]     b_i,
	input  logic                       hs_i,
	input  logic                       vs_i,
	input  mist_video_pkg::scanlines_t scanlines_i,
	input  mist_video_pkg::color_t     vga_r_i,
	input  mist_video_pkg::color_t     vga_g_i,
	input  mist_video_pkg::color_t     vga_b_i,
	input  logic                       vga_hs_i,
	input  logic                       vga_vs_i,
	output int                         fails_o
);

	mist_video_pkg::color_t wr;
	mist_video_pkg::color_t wg;
	mist_video_pkg::color_t wb;
	logic [17:0]            vga_pix;

	// Position of the current input pixel in the frame
	logic                   hs_prev;
	logic                   vs_prev;
	logic [9:0]             h_pos;
	logic [9:0]             v_pos;
	logic [17:0]            exp_pix [2];
	logic [1:0]             exp_sync [2];

	logic en_q;
	logic done_seen;
	logic in_hs_q;
	logic in_vs_q;
	logic out_hs_q;
	logic out_vs_q;
	logic prev_full;
	int   test_errs;
	int   hs_in_cnt;
	int   hs_out_cnt;
	int   vs_in_cnt;
	int   vs_out_cnt;
	int   lines_seen;
	int   countdown;
	int   tests_run;
	int   passed;
	int   failed;

	function automatic string test_name(logic [3:0] id);
		case (id)
			4'd0:    return "native_rgb";
			4'd1:    return "composite_sync";
			4'd2:    return "ypbpr";
			4'd3:    return "scandoubler_sl0";
			4'd4:    return "scandoubler_sl1";
			4'd5:    return "scandoubler_sl2";
			4'd6:    return "scandoubler_sl3";
			4'd7:    return "osd_enabled";
			default: return "osd_disabled";
		endcase
	endfunction

	// Bit i from the top is input bit (i mod depth) from the top
	function automatic mist_video_pkg::color_t widen(logic [COLOR_DEPTH-1:0] c);
		mist_video_pkg::color_t w;
		for (int i = 0; i < 6; i++)
			w[5-i] = c[COLOR_DEPTH-1-(i % COLOR_DEPTH)];
		return w;
	endfunction

	function automatic int floor64(int v);
		if (v >= 0)
			return v / 64;
		return -((-v + 63) / 64);
	endfunction

	function automatic mist_video_pkg::color_t clamp(int v);
		if (v < 0)
			return '0;
		if (v > 63)
			return 6'd63;
		return mist_video_pkg::color_t'(v);
	endfunction

	// Packed as {Pr, Y, Pb}
	function automatic logic [17:0] ypbpr(int r, int g, int b);
		mist_video_pkg::color_t y;
		y = mist_video_pkg::color_t'((19 * r + 37 * g + 8 * b) / 64);
		return {clamp(32 + floor64(32 * r - 27 * g - 5 * b)), y,
			clamp(32 + floor64(32 * b - 11 * r - 21 * g))};
	endfunction

	function automatic mist_video_pkg::color_t darken(mist_video_pkg::color_t c, int sl);
		case (sl)
			1:       return c - (c >> 2);
			2:       return c >> 1;
			3:       return c >> 2;
			default: return c;
		endcase
	endfunction

	function automatic mist_video_pkg::color_t osd_pixel(mist_video_pkg::color_t c, int h,
		int v, logic sel);
		int  col;
		int  row;
		logic lit;
		col = (h - int'(mist_video_pkg::OSD_X_OFFSET)) / 2;
		row = v - int'(mist_video_pkg::OSD_Y_OFFSET);
		if (h < int'(mist_video_pkg::OSD_X_OFFSET) || col >= mist_video_pkg::OSD_COLS ||
			row < 0 || row >= mist_video_pkg::OSD_ROWS)
			return c;
		lit = bitmap_i[col * 4 + row / 8][row % 8];
		if (lit && sel)
			return 6'd63;
		return c >> 1;
	endfunction

	function automatic logic [17:0] expected_pixel(logic [3:0] id, int h, int v);
		if (id == 4'd2)
			return ypbpr(wr, wg, wb);
		if (id == 4'd7)
			return {osd_pixel(wr, h, v, mist_video_pkg::OSD_COLOR[2]),
				osd_pixel(wg, h, v, mist_video_pkg::OSD_COLOR[1]),
				osd_pixel(wb, h, v, mist_video_pkg::OSD_COLOR[0])};
		return {wr, wg, wb};
	endfunction

	assign wr      = widen(r_i);
	assign wg      = widen(g_i);
	assign wb      = widen(b_i);
	assign vga_pix = {vga_r_i, vga_g_i, vga_b_i};

	// Expected results follow the 2 cycle pipeline
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			h_pos   <= '0;
			v_pos   <= '0;
		end else begin
			hs_prev <= hs_i;
			vs_prev <= vs_i;
			if (hs_prev && !hs_i)
				h_pos <= '0;
			else if (h_pos != '1)
				h_pos <= h_pos + 1'b1;
			if (vs_prev && !vs_i)
				v_pos <= '0;
			else if (hs_prev && !hs_i && v_pos != '1)
				v_pos <= v_pos + 1'b1;
		end
		exp_pix[0]  <= expected_pixel(test_id_i, h_pos, v_pos);
		exp_pix[1]  <= exp_pix[0];
		exp_sync[0] <= {~(hs_i ^ vs_i), 1'b1};
		exp_sync[1] <= exp_sync[0];
	end

	task automatic value_mismatch(int expected, int actual);
		if (test_errs < 4)
			$display("FAIL %s expected 0x%05h actual 0x%05h", test_name(test_id_i),
				expected, actual);
		test_errs++;
	endtask

	// One sample per doubled line, full and dimmed lines alternate
	task automatic sample_line();
		logic [17:0] full;
		logic [17:0] dim;
		logic [17:0] want;
		full = {wr, wg, wb};
		dim  = {darken(wr, scanlines_i), darken(wg, scanlines_i), darken(wb, scanlines_i)};
		if (lines_seen == 0) begin
			if (vga_pix == full)
				prev_full = 1'b1;
			else if (vga_pix == dim)
				prev_full = 1'b0;
			else
				value_mismatch(full, vga_pix);
		end else begin
			want = prev_full ? dim : full;
			if (vga_pix != want)
				value_mismatch(want, vga_pix);
			prev_full = ~prev_full;
		end
		lines_seen++;
	endtask

	task automatic scandoubler_step();
		if (hs_i && !in_hs_q)
			hs_in_cnt++;
		if (vs_i && !in_vs_q)
			vs_in_cnt++;
		if (vga_vs_i && !out_vs_q)
			vs_out_cnt++;
		if (vga_hs_i && !out_hs_q) begin
			hs_out_cnt++;
			countdown = 40;
		end else if (countdown > 0) begin
			countdown--;
			if (countdown == 0)
				sample_line();
		end
	endtask

	task automatic finish_test();
		if (test_id_i >= 4'd3 && test_id_i <= 4'd6) begin
			if (hs_in_cnt == 0) begin
				$display("%s: no input hsync pulse was seen", test_name(test_id_i));
				test_errs++;
			end else if (hs_out_cnt < 2 * hs_in_cnt - 2 || hs_out_cnt > 2 * hs_in_cnt + 2) begin
				value_mismatch(2 * hs_in_cnt, hs_out_cnt);
			end
			if (vs_in_cnt == 0 || vs_out_cnt < vs_in_cnt - 1 || vs_out_cnt > vs_in_cnt + 1)
				value_mismatch(vs_in_cnt, vs_out_cnt);
		end
		tests_run++;
		if (test_errs == 0) begin
			passed++;
			$display("%s: passed", test_name(test_id_i));
		end else begin
			failed++;
			$display("%s: failed with %0d mismatches", test_name(test_id_i), test_errs);
		end
		fails_o = failed;
	endtask

	initial begin
		en_q      = 1'b0;
		done_seen = 1'b0;
		tests_run = 0;
		passed    = 0;
		failed    = 0;
		fails_o   = 0;
	end

	always @(posedge clk_i) begin
		if (check_en_i && !en_q) begin
			test_errs  = 0;
			hs_in_cnt  = 0;
			hs_out_cnt = 0;
			vs_in_cnt  = 0;
			vs_out_cnt = 0;
			lines_seen = 0;
			countdown  = 0;
		end
		if (check_en_i) begin
			case (test_id_i)
				4'd1: begin
					if ({vga_hs_i, vga_vs_i} != exp_sync[1])
						value_mismatch(exp_sync[1], {vga_hs_i, vga_vs_i});
				end
				4'd3, 4'd4, 4'd5, 4'd6: scandoubler_step();
				default: begin
					if (vga_pix != exp_pix[1])
						value_mismatch(exp_pix[1], vga_pix);
				end
			endcase
		end
		if (!check_en_i && en_q)
			finish_test();
		if (done_i && !done_seen) begin
			$display("Tests run %0d, passed %0d, failed %0d", tests_run, passed, failed);
			done_seen = 1'b1;
		end
		en_q     = check_en_i;
		in_hs_q  = hs_i;
		in_vs_q  = vs_i;
		out_hs_q = vga_hs_i;
		out_vs_q = vga_vs_i;
	end

endmodule

// File: bench/tb_mist_video.sv
/* MiST video testbench */

`timescale 1ns/1ps

module tb_mist_video #(
	parameter int COLOR_DEPTH = 4
);

	// 96 pixels of 4 cycles per line, 40 lines per frame
	localparam int FRAME_NS  = 40 * 96 * 4 * 40;
	localparam int NUM_TESTS = 9;

	logic                       clk_sys;
	logic                       rst_i;
	logic [COLOR_DEPTH-1:0]     r_i;
	logic [COLOR_DEPTH-1:0]     g_i;
	logic [COLOR_DEPTH-1:0]     b_i;
	logic                       hs_i;
	logic                       vs_i;
	logic                       spi_sck_i;
	logic                       spi_ss_i;
	logic                       spi_di_i;
	mist_video_pkg::scanlines_t scanlines_i;
	logic                       scandoubler_disable_i;
	logic                       ypbpr_i;
	mist_video_pkg::color_t     vga_r_o;
	mist_video_pkg::color_t     vga_g_o;
	mist_video_pkg::color_t     vga_b_o;
	logic                       vga_hs_o;
	logic                       vga_vs_o;

	logic [3:0]  test_id;
	logic        check_en;
	logic        done;
	int          fails;
	logic [7:0]  osd_bitmap [256];
	logic [31:0] rng_state;
	logic        rand_colors;

	mist_video #(
		.COLOR_DEPTH (COLOR_DEPTH)
	) i_dut (
		.clk_sys               (clk_sys),
		.rst_i                 (rst_i),
		.r_i                   (r_i),
		.g_i                   (g_i),
		.b_i                   (b_i),
		.hs_i                  (hs_i),
		.vs_i                  (vs_i),
		.spi_sck_i             (spi_sck_i),
		.spi_ss_i              (spi_ss_i),
		.spi_di_i              (spi_di_i),
		.scanlines_i           (scanlines_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.ypbpr_i               (ypbpr_i),
		.vga_r_o               (vga_r_o),
		.vga_g_o               (vga_g_o),
		.vga_b_o               (vga_b_o),
		.vga_hs_o              (vga_hs_o),
		.vga_vs_o              (vga_vs_o)
	);

	video_checker #(
		.COLOR_DEPTH (COLOR_DEPTH)
	) i_checker (
		.clk_i       (clk_sys),
		.rst_i       (rst_i),
		.test_id_i   (test_id),
		.check_en_i  (check_en),
		.done_i      (done),
		.bitmap_i    (osd_bitmap),
		.r_i         (r_i),
		.g_i         (g_i),
		.b_i         (b_i),
		.hs_i        (hs_i),
		.vs_i        (vs_i),
		.scanlines_i (scanlines_i),
		.vga_r_i     (vga_r_o),
		.vga_g_i     (vga_g_o),
		.vga_b_i     (vga_b_o),
		.vga_hs_i    (vga_hs_o),
		.vga_vs_i    (vga_vs_o),
		.fails_o     (fails)
	);

	bind mist_video mist_video_assertions i_assertions (
		.clk_i                 (clk_sys),
		.rst_i                 (rst_i),
		.scandoubler_disable_i (scandoubler_disable_i),
		.ypbpr_i               (ypbpr_i),
		.vga_r_i               (vga_r_o),
		.vga_g_i               (vga_g_o),
		.vga_b_i               (vga_b_o),
		.vga_hs_i              (vga_hs_o),
		.vga_vs_i              (vga_vs_o)
	);

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// Hsync over the first 8 pixels, vsync over the first 3 lines
	task automatic play_frames(int n);
		for (int f = 0; f < n; f++) begin
			for (int line = 0; line < 40; line++) begin
				for (int px = 0; px < 96; px++) begin
					if (rand_colors) begin
						rng_state = xorshift(rng_state);
						r_i <= rng_state[COLOR_DEPTH-1:0];
						g_i <= rng_state[COLOR_DEPTH+7:8];
						b_i <= rng_state[COLOR_DEPTH+15:16];
					end
					hs_i <= (px < 8);
					vs_i <= (line < 3);
					repeat (4) @(posedge clk_sys);
				end
			end
		end
	endtask

	// One settling frame, then two checked frames
	task automatic run_test(logic [3:0] id);
		test_id <= id;
		play_frames(1);
		check_en <= 1'b1;
		play_frames(2);
		check_en <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic spi_send_byte(logic [7:0] data);
		for (int i = 7; i >= 0; i--) begin
			spi_di_i <= data[i];
			repeat (8) @(posedge clk_sys);
			spi_sck_i <= 1'b1;
			repeat (8) @(posedge clk_sys);
			spi_sck_i <= 1'b0;
		end
	endtask

	task automatic spi_command(logic [7:0] cmd);
		spi_ss_i <= 1'b0;
		repeat (8) @(posedge clk_sys);
		spi_send_byte(cmd);
		repeat (8) @(posedge clk_sys);
		spi_ss_i <= 1'b1;
		repeat (8) @(posedge clk_sys);
	endtask

	task automatic spi_load_bitmap();
		spi_ss_i <= 1'b0;
		repeat (8) @(posedge clk_sys);
		spi_send_byte(mist_video_pkg::OSD_CMD_WRITE);
		for (int a = 0; a < 256; a++)
			spi_send_byte(osd_bitmap[a]);
		repeat (8) @(posedge clk_sys);
		spi_ss_i <= 1'b1;
		repeat (8) @(posedge clk_sys);
	endtask

	initial begin
		rst_i                 <= 1'b1;
		r_i                   <= '0;
		g_i                   <= '0;
		b_i                   <= '0;
		hs_i                  <= 1'b0;
		vs_i                  <= 1'b0;
		spi_sck_i             <= 1'b0;
		spi_ss_i              <= 1'b1;
		spi_di_i              <= 1'b0;
		scanlines_i           <= mist_video_pkg::SL_NONE;
		scandoubler_disable_i <= 1'b1;
		ypbpr_i               <= 1'b0;
		test_id               <= '0;
		check_en              <= 1'b0;
		done                  <= 1'b0;
		rng_state = 32'd59;
		rand_colors = 1'b1;
		for (int a = 0; a < 256; a++) begin
			rng_state = xorshift(rng_state);
			osd_bitmap[a] = rng_state[7:0];
		end
		repeat (3) @(posedge clk_sys);
		rst_i <= 1'b0;

		run_test(4'd0);
		run_test(4'd1);
		ypbpr_i <= 1'b1;
		run_test(4'd2);

		// Constant color frames through the scandoubler
		ypbpr_i               <= 1'b0;
		scandoubler_disable_i <= 1'b0;
		rand_colors = 1'b0;
		r_i <= 4'hb;
		g_i <= 4'h6;
		b_i <= 4'h3;
		for (int sl = 0; sl < 4; sl++) begin
			scanlines_i <= mist_video_pkg::scanlines_t'(sl);
			run_test(4'd3 + 4'(sl));
		end

		scandoubler_disable_i <= 1'b1;
		scanlines_i           <= mist_video_pkg::SL_NONE;
		spi_load_bitmap();
		spi_command(mist_video_pkg::OSD_CMD_ENABLE);
		run_test(4'd7);
		spi_command(mist_video_pkg::OSD_CMD_DISABLE);
		run_test(4'd8);

		done <= 1'b1;
		repeat (3) @(posedge clk_sys);
		if (fails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Five frames per test leaves room for settling and the SPI load
	initial begin
		#(longint'(NUM_TESTS) * 5 * FRAME_NS + 100000);
		$display("Timeout: the tests did not finish in the allowed simulation time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: mist_video.f
hdl/mist_video_pkg.sv
hdl/video_if.sv
hdl/scandoubler.sv
hdl/osd.sv
hdl/video_out_encoder.sv
hdl/mist_video.sv
bench/mist_video_assertions.sv
bench/video_checker.sv
bench/tb_mist_video.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mist_video testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f mist_video.f --top-module tb_mist_video -o tb_mist_video
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_mist_video > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

exit 0
